//--- fft_twdl_pkg.sv
package fft_twdl_pkg;

	// ************************************************************
	// widths and latencies
	// ************************************************************

	localparam logic [2:0] LANES = 3'd5;
	localparam int W_DATA = 30;
	localparam int W_COEF = 16;
	localparam int COEF_FRAC = 14;	// q1.14, 16384 is 1.0.
	localparam int W_PROD = W_DATA + W_COEF;
	localparam int W_NUM = 12;
	localparam int W_PHASE = 16;
	localparam int W_WB = 32;

	localparam int CORDIC_STAGES = 14;
	localparam int CORDIC_GUARD = 4;	// extra fraction bits inside the rotator.
	localparam int CORDIC_HALF = 1 << (CORDIC_GUARD - 1);
	localparam int W_CX = W_COEF + CORDIC_GUARD + 1;
	localparam int W_CZ = W_PHASE + CORDIC_GUARD;	// 2^20 per turn.
	localparam int CORDIC_GAIN_INIT = 9948;	// 16384 / 1.647.

	localparam int COEF_LAT = 16;	// phase mult + 14 stages + output reg.
	localparam int TWDL_LAT = 18;

	localparam logic [1:0] REG_DEN = 2'd0;
	localparam logic [1:0] REG_STEP = 2'd1;
	localparam logic [1:0] REG_CNT = 2'd2;

	// ************************************************************
	// types
	// ************************************************************

	typedef logic signed [W_DATA-1:0] data_t;
	typedef logic signed [W_COEF-1:0] coef_t;
	typedef logic signed [W_PROD-1:0] prod_t;
	typedef logic [W_NUM-1:0] twdl_num_t;
	typedef logic [W_PHASE-1:0] phase_t;	// fraction of a full turn.

	typedef struct packed {
		data_t re;
		data_t im;
	} cplx_t;

	typedef struct packed {
		coef_t c_re;
		coef_t c_im;
	} coef_pair_t;

	typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_DONE} div_state_t;

endpackage

//--- src.f
fft_twdl_pkg.sv
twdl_recip_div.sv
twdl_cordic.sv
twdl_cfg_wb.sv
twdl_cmul.sv
twdl_top.sv
tb_twdl_top.sv

//--- tb_twdl_top.sv
`timescale 1ns/1ps

module tb_twdl_top import fft_twdl_pkg::*; ();

	logic clk;
	logic rst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [1:0] wb_adr;
	logic [W_WB-1:0] wb_dat_w;
	logic [W_WB-1:0] wb_dat_r;
	logic wb_ack;
	logic in_val;
	twdl_num_t twdl_num [LANES];
	cplx_t din [LANES];
	logic out_val;
	cplx_t dout [LANES];

	int cycle = 0;
	int errors = 0;
	int n_checks = 0;
	int smp_total = 0;
	logic [31:0] rnd_state = 32'h812f;
	int exp_cyc [$];
	longint exp_re [$];
	longint exp_im [$];

	// ************************************************************
	// stimulus table: denominator, numerators, samples, step
	// ************************************************************

	int tab_den [8] = '{1, 3, 4, 5, 15, 25, 4095, 0};
	int tab_cnt [8] = '{16, 12, 16, 12, 16, 12, 16, 12};
	int tab_step [8] = '{65535, 21845, 16384, 13107, 4369, 2621, 16, 0};
	int tab_num [8][5] = '{'{0, 1, 2, 100, 4095}, '{0, 1, 2, 3, 4}, '{0, 1, 2, 3, 7},
		'{1, 2, 3, 4, 9}, '{1, 4, 7, 11, 14}, '{3, 8, 13, 19, 24},
		'{1, 1024, 2047, 3071, 4094}, '{5, 17, 300, 1000, 4095}};

	twdl_top u_dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.in_val   (in_val),
		.twdl_num (twdl_num),
		.din      (din),
		.out_val  (out_val),
		.dout     (dout)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic longint round_real(input real x);
		return $rtoi($floor(x + 0.5));
	endfunction

	function automatic int step_of(input int den);
		if (den == 0) return 0;
		return (65536 / den > 65535) ? 65535 : 65536 / den;
	endfunction

	// data times e^(-j*2*pi*phase/65536) with q1.14 coefficients.
	function automatic void rotate(input int step, input int num, input longint re,
			input longint im, output longint ore, output longint oim);
		int ph;
		real ang;
		real cr;
		real ci;
		ph = (num * step) % 65536;
		ang = 2.0 * 3.14159265358979 * ph / 65536.0;
		cr = round_real(16384.0 * $cos(ang));
		ci = round_real(-16384.0 * $sin(ang));
		ore = round_real((re * cr - im * ci) / 16384.0);
		oim = round_real((re * ci + im * cr) / 16384.0);
	endfunction

	task automatic check(input string name, input longint got, input longint exp,
			input longint tol);
		n_checks++;
		if (got - exp > tol || exp - got > tol) begin
			errors++;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic wait_ack(input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (!wb_ack && n < 64) begin
			@(negedge clk);
			n++;
		end
		if (!wb_ack) begin
			errors++;
			$display("wishbone %s never got an ack", what);
		end
	endtask

	task automatic wb_write(input logic [1:0] adr, input logic [31:0] dat);
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= 1'b1;
		wb_adr <= adr;
		wb_dat_w <= dat;
		wait_ack("write");
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic wb_read(input logic [1:0] adr, output logic [31:0] dat);
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= 1'b0;
		wb_adr <= adr;
		wait_ack("read");
		dat = wb_dat_r;
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
	endtask

	// idle cycles carry random numerators to expose misaligned coefficients.
	task automatic scramble_num();
		rnd_state = xorshift(rnd_state);
		for (int l = 0; l < LANES; l++) begin
			twdl_num[l] <= twdl_num_t'(rnd_state[l*4 +: W_NUM]);
		end
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (exp_cyc.size() != 0 && n < 200) begin
			@(negedge clk);
			n++;
		end
		if (exp_cyc.size() != 0) begin
			errors++;
			$display("timeout, %0d samples never left the pipeline", exp_cyc.size());
			exp_cyc.delete();
			exp_re.delete();
			exp_im.delete();
		end
	endtask

	task automatic run_row(input int r);
		logic [31:0] rd;
		int e0;
		int gap;
		longint re;
		longint im;
		longint ore;
		longint oim;
		e0 = errors;
		wb_write(REG_DEN, tab_den[r]);
		wb_read(REG_DEN, rd);
		check("reg den", rd, tab_den[r], 0);
		wb_read(REG_STEP, rd);
		check("reg step", rd, tab_step[r], 0);
		for (int k = 0; k < tab_cnt[r]; k++) begin
			rnd_state = xorshift(rnd_state);
			gap = (r % 2 == 0) ? 0 : int'(rnd_state[1:0]);	// even rows run back to back.
			repeat (gap) begin
				@(posedge clk);
				in_val <= 1'b0;
				scramble_num();
			end
			@(posedge clk);
			in_val <= 1'b1;
			exp_cyc.push_back(cycle + 1);	// count once this edge is done.
			for (int l = 0; l < LANES; l++) begin
				rnd_state = xorshift(rnd_state);
				re = longint'($signed(rnd_state[12:0]));
				im = longint'($signed(rnd_state[28:16]));
				twdl_num[l] <= twdl_num_t'(tab_num[r][l]);
				din[l].re <= data_t'(re);
				din[l].im <= data_t'(im);
				rotate(step_of(tab_den[r]), tab_num[r][l], re, im, ore, oim);
				exp_re.push_back(ore);
				exp_im.push_back(oim);
			end
		end
		@(posedge clk);
		in_val <= 1'b0;
		scramble_num();
		drain();
		smp_total += tab_cnt[r];
		wb_read(REG_CNT, rd);
		check("reg cnt", rd, smp_total, 0);
		$display("row %0d, N = %0d, %0d samples: %0d errors", r, tab_den[r], tab_cnt[r],
			errors - e0);
	endtask

	// ************************************************************
	// output monitor
	// ************************************************************

	always @(negedge clk) begin
		if (rst_n && out_val) begin
			if (exp_cyc.size() == 0) begin
				errors++;
				$display("out_val came with no sample in flight");
			end else begin
				check("latency", cycle - exp_cyc.pop_front(), TWDL_LAT, 0);
				for (int l = 0; l < LANES; l++) begin
					check($sformatf("dout[%0d].re", l), dout[l].re, exp_re.pop_front(), 6);
					check($sformatf("dout[%0d].im", l), dout[l].im, exp_im.pop_front(), 6);
				end
			end
		end
	end

	initial begin
		logic [31:0] rd;
		int e0;
		rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		in_val = 1'b0;
		for (int l = 0; l < LANES; l++) begin
			twdl_num[l] = '0;
			din[l] = '0;
		end
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		e0 = errors;
		check("out_val", out_val, 0, 0);
		for (int l = 0; l < LANES; l++) begin
			check($sformatf("dout[%0d]", l), dout[l], 0, 0);
		end
		wb_read(REG_DEN, rd);
		check("reg den", rd, 1, 0);
		wb_read(REG_STEP, rd);
		check("reg step", rd, 65535, 0);
		wb_read(REG_CNT, rd);
		check("reg cnt", rd, 0, 0);
		$display("reset state: %0d errors", errors - e0);
		for (int r = 0; r < 8; r++) begin
			run_row(r);
		end
		e0 = errors;
		wb_write(REG_CNT, 32'd0);
		wb_read(REG_CNT, rd);
		check("reg cnt", rd, 0, 0);
		$display("counter clear: %0d errors", errors - e0);
		$display("checks %0d, errors %0d", n_checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- twdl_cfg_wb.sv
`timescale 1ns/1ps

module twdl_cfg_wb import fft_twdl_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            cyc,
	input  logic            stb,
	input  logic            we,
	input  logic [1:0]      adr,
	input  logic [W_WB-1:0] dat_w,
	output logic [W_WB-1:0] dat_r,
	output logic            ack,
	input  logic            out_val,
	output phase_t          step
);

	logic req;
	logic den_wr;
	logic div_start;
	logic div_done;
	logic den_wait;
	logic ack_q;
	twdl_num_t den_q;
	logic [W_WB-1:0] smp_cnt;

	assign req = cyc && stb && !ack;
	assign den_wr = req && we && (adr == REG_DEN);
	assign div_start = den_wr && !den_wait;
	assign ack = ack_q || (den_wait && div_done);	// denominator write ends on done.

	twdl_recip_div u_div (
		.clk   (clk),
		.rst_n (rst_n),
		.start (div_start),
		.den   (dat_w[W_NUM-1:0]),
		.step  (step),
		.done  (div_done)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
			den_wait <= 1'b0;
			den_q <= W_NUM'(1);
			dat_r <= '0;
		end else begin
			ack_q <= req && !den_wr;
			if (div_start) begin
				den_wait <= 1'b1;
				den_q <= dat_w[W_NUM-1:0];
			end else if (div_done) begin
				den_wait <= 1'b0;
			end
			if (req && !we) begin
				case (adr)
					REG_DEN: dat_r <= W_WB'(den_q);
					REG_STEP: dat_r <= W_WB'(step);
					REG_CNT: dat_r <= smp_cnt;
					default: dat_r <= '0;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			smp_cnt <= '0;
		end else if (req && we && (adr == REG_CNT)) begin
			smp_cnt <= '0;
		end else if (out_val) begin
			smp_cnt <= smp_cnt + 1'b1;	// wraps.
		end
	end

endmodule

//--- twdl_cmul.sv
`timescale 1ns/1ps

module twdl_cmul import fft_twdl_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       in_val,
	input  cplx_t      din [LANES],
	input  coef_pair_t coef [LANES],
	output logic       out_val,
	output cplx_t      dout [LANES]
);

	cplx_t d_sr [LANES][COEF_LAT];
	logic [COEF_LAT-1:0] val_sr;
	logic val_p;
	prod_t p_re [LANES];
	prod_t p_im [LANES];

	// bits 43:14 plus bit 13, half-up.
	function automatic data_t round_q14(input prod_t p);
		return data_t'(p[COEF_FRAC +: W_DATA] + p[COEF_FRAC-1]);
	endfunction

	// ************************************************************
	// alignment with the coefficient stream
	// ************************************************************

	always_ff @(posedge clk) begin
		for (int l = 0; l < LANES; l++) begin
			d_sr[l][0] <= din[l];
			for (int t = 1; t < COEF_LAT; t++) begin
				d_sr[l][t] <= d_sr[l][t-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			val_sr <= '0;
			val_p <= 1'b0;
			out_val <= 1'b0;
		end else begin
			val_sr <= {val_sr[COEF_LAT-2:0], in_val};
			val_p <= val_sr[COEF_LAT-1];
			out_val <= val_p;
		end
	end

	// ************************************************************
	// complex multiply and rounding
	// ************************************************************

	always_ff @(posedge clk) begin
		for (int l = 0; l < LANES; l++) begin
			p_re[l] <= d_sr[l][COEF_LAT-1].re * coef[l].c_re
			           - d_sr[l][COEF_LAT-1].im * coef[l].c_im;
			p_im[l] <= d_sr[l][COEF_LAT-1].re * coef[l].c_im
			           + d_sr[l][COEF_LAT-1].im * coef[l].c_re;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int l = 0; l < LANES; l++) begin
				dout[l] <= '0;
			end
		end else begin
			for (int l = 0; l < LANES; l++) begin
				dout[l].re <= val_p ? round_q14(p_re[l]) : '0;	// idle lanes read zero.
				dout[l].im <= val_p ? round_q14(p_im[l]) : '0;
			end
		end
	end

endmodule

//--- twdl_cordic.sv
`timescale 1ns/1ps

module twdl_cordic import fft_twdl_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  twdl_num_t  num,
	input  phase_t     step,
	output coef_pair_t coef
);

	typedef struct packed {
		logic signed [W_CX-1:0] x;
		logic signed [W_CX-1:0] y;
		logic signed [W_CZ-1:0] z;
	} rot_t;

	phase_t phase_q;
	logic [1:0] quad;
	logic signed [W_CX-1:0] x_init;
	rot_t fold;
	rot_t st_q [CORDIC_STAGES];
	rot_t last;

	// atan(2^-k) in units of 2^-20 turn.
	function automatic logic signed [W_CZ-1:0] atan_lut(input int k);
		logic signed [W_CZ-1:0] a;
		case (k)
			0: a = W_CZ'(131072);	// 45 degrees.
			1: a = W_CZ'(77376);
			2: a = W_CZ'(40884);
			3: a = W_CZ'(20753);
			4: a = W_CZ'(10417);
			5: a = W_CZ'(5213);
			6: a = W_CZ'(2607);
			7: a = W_CZ'(1304);
			8: a = W_CZ'(652);
			9: a = W_CZ'(326);
			10: a = W_CZ'(163);
			11: a = W_CZ'(81);
			12: a = W_CZ'(41);
			13: a = W_CZ'(20);
			default: a = '0;
		endcase
		return a;
	endfunction

	function automatic rot_t rot_step(input rot_t s, input int k);
		rot_t n;
		logic signed [W_CX-1:0] dx;
		logic signed [W_CX-1:0] dy;
		dx = s.x >>> k;
		dy = s.y >>> k;
		if (s.z[W_CZ-1]) begin	// residual negative, turn clockwise.
			n.x = s.x + dy;
			n.y = s.y - dx;
			n.z = s.z + atan_lut(k);
		end else begin
			n.x = s.x - dy;
			n.y = s.y + dx;
			n.z = s.z - atan_lut(k);
		end
		return n;
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phase_q <= '0;
		end else begin
			phase_q <= phase_t'(num * step);	// low bits wrap the turn.
		end
	end

	// ************************************************************
	// quadrant fold
	// ************************************************************

	assign quad = phase_q[W_PHASE-1 -: 2];
	assign x_init = W_CX'(CORDIC_GAIN_INIT << CORDIC_GUARD);

	always_comb begin
		fold.x = '0;
		fold.y = '0;
		fold.z = W_CZ'({phase_q[W_PHASE-3:0], {CORDIC_GUARD{1'b0}}});
		case (quad)
			2'd0: fold.x = x_init;
			2'd1: fold.y = x_init;	// start at 90 degrees.
			2'd2: fold.x = -x_init;
			default: fold.y = -x_init;
		endcase
	end

	// ************************************************************
	// rotation stages
	// ************************************************************

	always_ff @(posedge clk) begin
		st_q[0] <= rot_step(fold, 0);
		for (int k = 1; k < CORDIC_STAGES; k++) begin
			st_q[k] <= rot_step(st_q[k-1], k);
		end
	end

	assign last = st_q[CORDIC_STAGES-1];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			coef <= '0;
		end else begin
			coef.c_re <= coef_t'((last.x + CORDIC_HALF) >>> CORDIC_GUARD);
			coef.c_im <= coef_t'(-((last.y + CORDIC_HALF) >>> CORDIC_GUARD));	// e^-j.
		end
	end

endmodule

//--- twdl_recip_div.sv
`timescale 1ns/1ps

module twdl_recip_div import fft_twdl_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      start,
	input  twdl_num_t den,
	output phase_t    step,
	output logic      done
);

	div_state_t state;
	twdl_num_t den_q;
	twdl_num_t rem;
	phase_t quo;
	logic [$clog2(W_PHASE)-1:0] bit_cnt;
	logic [W_NUM:0] rem_sh;
	logic fits;

	assign rem_sh = {rem, 1'b0};
	assign fits = (rem_sh >= {1'b0, den_q});	// den of 1 keeps every bit set.
	assign done = (state == DIV_DONE);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= DIV_IDLE;
			step <= '1;	// 65536/1 saturated.
			bit_cnt <= '0;
		end else begin
			case (state)
				DIV_IDLE: begin
					if (start) begin
						state <= DIV_RUN;
						bit_cnt <= '0;
					end
				end
				DIV_RUN: begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == W_PHASE - 1) begin
						state <= DIV_DONE;
						step <= (den_q == '0) ? '0 : {quo[W_PHASE-2:0], fits};
					end
				end
				default: state <= DIV_IDLE;
			endcase
		end
	end

	// restoring datapath, one quotient bit per cycle.
	always_ff @(posedge clk) begin
		if (state == DIV_IDLE && start) begin
			den_q <= den;
			rem <= W_NUM'(1);	// remainder after the leading bit of 2^16.
			quo <= '0;
		end else if (state == DIV_RUN) begin
			rem <= fits ? W_NUM'(rem_sh - {1'b0, den_q}) : rem_sh[W_NUM-1:0];
			quo <= {quo[W_PHASE-2:0], fits};
		end
	end

endmodule

//--- twdl_top.sv
`timescale 1ns/1ps

module twdl_top import fft_twdl_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            wb_cyc,
	input  logic            wb_stb,
	input  logic            wb_we,
	input  logic [1:0]      wb_adr,
	input  logic [W_WB-1:0] wb_dat_w,
	output logic [W_WB-1:0] wb_dat_r,
	output logic            wb_ack,
	input  logic            in_val,
	input  twdl_num_t       twdl_num [LANES],
	input  cplx_t           din [LANES],
	output logic            out_val,
	output cplx_t           dout [LANES]
);

	phase_t step;
	coef_pair_t coef [LANES];

	twdl_cfg_wb u_cfg (
		.clk     (clk),
		.rst_n   (rst_n),
		.cyc     (wb_cyc),
		.stb     (wb_stb),
		.we      (wb_we),
		.adr     (wb_adr),
		.dat_w   (wb_dat_w),
		.dat_r   (wb_dat_r),
		.ack     (wb_ack),
		.out_val (out_val),
		.step    (step)
	);

	// one rotator per lane, all sharing the phase step.
	for (genvar i = 0; i < LANES; i++) begin : g_lane
		twdl_cordic u_cordic (
			.clk   (clk),
			.rst_n (rst_n),
			.num   (twdl_num[i]),
			.step  (step),
			.coef  (coef[i])
		);
	end

	twdl_cmul u_cmul (
		.clk     (clk),
		.rst_n   (rst_n),
		.in_val  (in_val),
		.din     (din),
		.coef    (coef),
		.out_val (out_val),
		.dout    (dout)
	);

endmodule
